/* project.f */
source/periph_pkg.sv
source/periph_reg_decode.sv
source/periph_timer.sv
source/periph_uart_tx.sv
source/periph_plic.sv
source/soc_peripherals.sv
verification/tb_soc_peripherals.sv

/* source/periph_pkg.sv */
/*
 * Peripheral subsystem package
 * Bus widths, address map, register offsets, PLIC sizing and UART states
 */
package periph_pkg;

    typedef logic [11:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [5:0]  offset_t;
    typedef logic [3:0]  region_t;
    typedef logic [1:0]  src_id_t;
    typedef logic [2:0]  prio_t;

    // Region number sits in address bits 11:8
    localparam region_t REGION_PLIC  = 4'd0;
    localparam region_t REGION_UART  = 4'd1;
    localparam region_t REGION_TIMER = 4'd2;

    localparam data_t ERR_READ_DATA = 32'hDEAD_BEEF;

    localparam int    NUM_TIMERS     = 2;
    localparam int    NUM_SOURCES    = 3;
    localparam int    NUM_TARGETS    = 2;
    localparam prio_t MAX_PRIORITY   = 3'd7;
    localparam data_t UART_DIV_RESET = 32'd4;

    // --------------------------------------------------
    // Word offsets inside each region
    // --------------------------------------------------
    // Timer channel c adds 4*c
    localparam offset_t TMR_CTRL   = 6'd0;
    localparam offset_t TMR_COUNT  = 6'd1;
    localparam offset_t TMR_CMP    = 6'd2;
    localparam offset_t TMR_STATUS = 6'd3;

    localparam offset_t UART_TXDATA = 6'd0;
    localparam offset_t UART_STATUS = 6'd1;
    localparam offset_t UART_DIV    = 6'd2;
    localparam offset_t UART_CTRL   = 6'd3;

    // Bases, plus source id or target index
    localparam offset_t PLIC_PRIO    = 6'd0;
    localparam offset_t PLIC_PENDING = 6'd8;
    localparam offset_t PLIC_ENABLE  = 6'd16;
    localparam offset_t PLIC_THRESH  = 6'd24;
    localparam offset_t PLIC_CLAIM   = 6'd32;

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_e;

endpackage

/* source/periph_plic.sv */
/*
 * Platform-level interrupt controller, level sources only
 * Gateways, priorities, per-target enables and thresholds, claim/complete
 */
`timescale 1ns/1ns

module periph_plic (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 sel_i,
    input  logic                                 we_i,
    input  periph_pkg::offset_t                  offset_i,
    input  periph_pkg::data_t                    wdata_i,
    output periph_pkg::data_t                    rdata_o,
    input  logic [periph_pkg::NUM_SOURCES-1:0]   src_i,
    output logic [periph_pkg::NUM_TARGETS-1:0]   irq_o
);

    // Bit s of these vectors belongs to source id s+1
    logic [periph_pkg::NUM_SOURCES-1:0] pending;
    logic [periph_pkg::NUM_SOURCES-1:0] in_service;
    periph_pkg::prio_t                  prio     [periph_pkg::NUM_SOURCES];
    logic [periph_pkg::NUM_SOURCES-1:0] enable   [periph_pkg::NUM_TARGETS];
    periph_pkg::prio_t                  thresh   [periph_pkg::NUM_TARGETS];
    periph_pkg::src_id_t                claim_id [periph_pkg::NUM_TARGETS];
    logic [periph_pkg::NUM_TARGETS-1:0] claim_rd;
    logic [periph_pkg::NUM_TARGETS-1:0] complete_wr;

    // Saturate written priorities and thresholds at the top level
    function automatic periph_pkg::prio_t sat_prio(periph_pkg::data_t value);
        if (value > periph_pkg::data_t'(periph_pkg::MAX_PRIORITY)) begin
            return periph_pkg::MAX_PRIORITY;
        end
        return periph_pkg::prio_t'(value);
    endfunction

    // --------------------------------------------------
    // Best candidate per target
    // --------------------------------------------------
    always_comb begin
        periph_pkg::prio_t   best_prio;
        periph_pkg::src_id_t best_id;
        for (int t = 0; t < periph_pkg::NUM_TARGETS; t++) begin
            best_prio = '0;
            best_id   = '0;
            // Strict compare keeps the lowest id on a tie
            for (int s = 0; s < periph_pkg::NUM_SOURCES; s++) begin
                if (pending[s] && enable[t][s] && (prio[s] > best_prio)) begin
                    best_prio = prio[s];
                    best_id   = periph_pkg::src_id_t'(s + 1);
                end
            end
            irq_o[t]       = best_prio > thresh[t];
            claim_id[t]    = irq_o[t] ? best_id : '0;
            claim_rd[t]    = sel_i && !we_i &&
                             (offset_i == periph_pkg::PLIC_CLAIM + periph_pkg::offset_t'(t));
            complete_wr[t] = sel_i && we_i &&
                             (offset_i == periph_pkg::PLIC_CLAIM + periph_pkg::offset_t'(t));
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending    <= '0;
            in_service <= '0;
            for (int s = 0; s < periph_pkg::NUM_SOURCES; s++) begin
                prio[s] <= '0;
            end
            for (int t = 0; t < periph_pkg::NUM_TARGETS; t++) begin
                enable[t] <= '0;
                thresh[t] <= '0;
            end
        end else begin
            for (int s = 0; s < periph_pkg::NUM_SOURCES; s++) begin
                // Gateway, a source in service cannot pend again
                if (src_i[s] && !in_service[s]) begin
                    pending[s] <= 1'b1;
                end
                if (sel_i && we_i &&
                    (offset_i == periph_pkg::PLIC_PRIO + periph_pkg::offset_t'(s + 1))) begin
                    prio[s] <= sat_prio(wdata_i);
                end
                for (int t = 0; t < periph_pkg::NUM_TARGETS; t++) begin
                    if (claim_rd[t] && (claim_id[t] == periph_pkg::src_id_t'(s + 1))) begin
                        pending[s]    <= 1'b0;
                        in_service[s] <= 1'b1;
                    end
                    if (complete_wr[t] && (wdata_i == periph_pkg::data_t'(s + 1))) begin
                        in_service[s] <= 1'b0;
                    end
                end
            end
            for (int t = 0; t < periph_pkg::NUM_TARGETS; t++) begin
                if (sel_i && we_i &&
                    (offset_i == periph_pkg::PLIC_ENABLE + periph_pkg::offset_t'(t))) begin
                    enable[t] <= wdata_i[periph_pkg::NUM_SOURCES:1];
                end
                if (sel_i && we_i &&
                    (offset_i == periph_pkg::PLIC_THRESH + periph_pkg::offset_t'(t))) begin
                    thresh[t] <= sat_prio(wdata_i);
                end
            end
        end
    end

    // Read mux, pending and enable use bit id for source id
    always_comb begin
        rdata_o = '0;
        for (int s = 0; s < periph_pkg::NUM_SOURCES; s++) begin
            if (offset_i == periph_pkg::PLIC_PRIO + periph_pkg::offset_t'(s + 1)) begin
                rdata_o = periph_pkg::data_t'(prio[s]);
            end
        end
        if (offset_i == periph_pkg::PLIC_PENDING) begin
            rdata_o = periph_pkg::data_t'({pending, 1'b0});
        end
        for (int t = 0; t < periph_pkg::NUM_TARGETS; t++) begin
            if (offset_i == periph_pkg::PLIC_ENABLE + periph_pkg::offset_t'(t)) begin
                rdata_o = periph_pkg::data_t'({enable[t], 1'b0});
            end else if (offset_i == periph_pkg::PLIC_THRESH + periph_pkg::offset_t'(t)) begin
                rdata_o = periph_pkg::data_t'(thresh[t]);
            end else if (claim_rd[t] || complete_wr[t]) begin
                rdata_o = periph_pkg::data_t'(claim_id[t]);
            end
        end
    end

endmodule

/* source/periph_reg_decode.sv */
/*
 * Register bus decoder
 * Routes each request to one region and returns a registered response,
 * with an error and fixed data for unmapped regions
 */
`timescale 1ns/1ns

module periph_reg_decode (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                req_i,
    input  logic                we_i,
    input  periph_pkg::addr_t   addr_i,
    input  periph_pkg::data_t   wdata_i,
    output logic                plic_sel_o,
    output logic                uart_sel_o,
    output logic                timer_sel_o,
    output logic                we_o,
    output periph_pkg::offset_t offset_o,
    output periph_pkg::data_t   wdata_o,
    input  periph_pkg::data_t   plic_rdata_i,
    input  periph_pkg::data_t   uart_rdata_i,
    input  periph_pkg::data_t   timer_rdata_i,
    output logic                rsp_valid_o,
    output periph_pkg::data_t   rdata_o,
    output logic                err_o
);

    periph_pkg::region_t region;
    logic                mapped;
    periph_pkg::data_t   sel_rdata;

    assign region   = addr_i[11:8];
    assign offset_o = addr_i[7:2];
    assign we_o     = we_i;
    assign wdata_o  = wdata_i;

    // Only one select can be high, and only in the request cycle
    assign plic_sel_o  = req_i && (region == periph_pkg::REGION_PLIC);
    assign uart_sel_o  = req_i && (region == periph_pkg::REGION_UART);
    assign timer_sel_o = req_i && (region == periph_pkg::REGION_TIMER);
    assign mapped      = plic_sel_o || uart_sel_o || timer_sel_o;

    always_comb begin
        if (plic_sel_o) begin
            sel_rdata = plic_rdata_i;
        end else if (uart_sel_o) begin
            sel_rdata = uart_rdata_i;
        end else if (timer_sel_o) begin
            sel_rdata = timer_rdata_i;
        end else begin
            sel_rdata = periph_pkg::ERR_READ_DATA;
        end
    end

    // --------------------------------------------------
    // One-cycle response
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_o <= 1'b0;
            err_o       <= 1'b0;
        end else begin
            rsp_valid_o <= req_i;
            err_o       <= req_i && !mapped;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_o <= sel_rdata;
        end
    end

endmodule

/* source/periph_timer.sv */
/*
 * Compare timers
 * Each channel counts while enabled, wraps on compare match and raises
 * a sticky flag that software clears through the status register
 */
`timescale 1ns/1ns

module periph_timer (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                sel_i,
    input  logic                                we_i,
    input  periph_pkg::offset_t                 offset_i,
    input  periph_pkg::data_t                   wdata_i,
    output periph_pkg::data_t                   rdata_o,
    output logic [periph_pkg::NUM_TIMERS-1:0]   irq_o
);

    logic [periph_pkg::NUM_TIMERS-1:0] enable;
    logic [periph_pkg::NUM_TIMERS-1:0] flag;
    periph_pkg::data_t                 count [periph_pkg::NUM_TIMERS];
    periph_pkg::data_t                 cmp   [periph_pkg::NUM_TIMERS];
    periph_pkg::offset_t               base  [periph_pkg::NUM_TIMERS];
    logic [periph_pkg::NUM_TIMERS-1:0] wr_ctrl;
    logic [periph_pkg::NUM_TIMERS-1:0] wr_count;
    logic [periph_pkg::NUM_TIMERS-1:0] wr_cmp;
    logic [periph_pkg::NUM_TIMERS-1:0] wr_status;

    assign irq_o = flag;

    // Per-channel write strobes, channel c starts at word 4*c
    always_comb begin
        for (int c = 0; c < periph_pkg::NUM_TIMERS; c++) begin
            base[c]      = periph_pkg::offset_t'(4 * c);
            wr_ctrl[c]   = sel_i && we_i && (offset_i == base[c] + periph_pkg::TMR_CTRL);
            wr_count[c]  = sel_i && we_i && (offset_i == base[c] + periph_pkg::TMR_COUNT);
            wr_cmp[c]    = sel_i && we_i && (offset_i == base[c] + periph_pkg::TMR_CMP);
            wr_status[c] = sel_i && we_i && (offset_i == base[c] + periph_pkg::TMR_STATUS);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enable <= '0;
            flag   <= '0;
            for (int c = 0; c < periph_pkg::NUM_TIMERS; c++) begin
                count[c] <= '0;
                cmp[c]   <= '0;
            end
        end else begin
            for (int c = 0; c < periph_pkg::NUM_TIMERS; c++) begin
                if (enable[c]) begin
                    if (count[c] == cmp[c]) begin
                        count[c] <= '0;
                        flag[c]  <= 1'b1;
                    end else begin
                        count[c] <= count[c] + 32'd1;
                    end
                end
                // Bus writes take priority over counting
                if (wr_ctrl[c]) begin
                    enable[c] <= wdata_i[0];
                end
                if (wr_count[c]) begin
                    count[c] <= wdata_i;
                end
                if (wr_cmp[c]) begin
                    cmp[c] <= wdata_i;
                end
                if (wr_status[c]) begin
                    flag[c] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        for (int c = 0; c < periph_pkg::NUM_TIMERS; c++) begin
            if (offset_i == base[c] + periph_pkg::TMR_CTRL) begin
                rdata_o = periph_pkg::data_t'(enable[c]);
            end else if (offset_i == base[c] + periph_pkg::TMR_COUNT) begin
                rdata_o = count[c];
            end else if (offset_i == base[c] + periph_pkg::TMR_CMP) begin
                rdata_o = cmp[c];
            end else if (offset_i == base[c] + periph_pkg::TMR_STATUS) begin
                rdata_o = periph_pkg::data_t'(flag[c]);
            end
        end
    end

endmodule

/* source/periph_uart_tx.sv */
/*
 * UART transmitter
 * Sends one start bit, eight data bits LSB first and one stop bit,
 * each lasting the programmed number of clocks
 */
`timescale 1ns/1ns

module periph_uart_tx (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                sel_i,
    input  logic                we_i,
    input  periph_pkg::offset_t offset_i,
    input  periph_pkg::data_t   wdata_i,
    output periph_pkg::data_t   rdata_o,
    output logic                irq_o,
    output logic                tx_o
);

    periph_pkg::uart_state_e state;
    periph_pkg::data_t       div;
    periph_pkg::data_t       cyc_cnt;
    logic [7:0]              shift;
    logic [2:0]              bit_cnt;
    logic                    irq_en;
    logic                    bit_done;
    logic                    load;

    assign bit_done = (cyc_cnt == div - 32'd1);
    // Writes while a frame is running are dropped
    assign load     = sel_i && we_i && (offset_i == periph_pkg::UART_TXDATA)
                      && (state == periph_pkg::IDLE);
    assign irq_o    = irq_en && (state == periph_pkg::IDLE);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state   <= periph_pkg::IDLE;
            div     <= periph_pkg::UART_DIV_RESET;
            irq_en  <= 1'b0;
            cyc_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            if (sel_i && we_i && (offset_i == periph_pkg::UART_DIV)) begin
                div <= wdata_i;
            end
            if (sel_i && we_i && (offset_i == periph_pkg::UART_CTRL)) begin
                irq_en <= wdata_i[0];
            end

            if (state == periph_pkg::IDLE) begin
                cyc_cnt <= '0;
                if (load) begin
                    state <= periph_pkg::START;
                end
            end else if (!bit_done) begin
                cyc_cnt <= cyc_cnt + 32'd1;
            end else begin
                cyc_cnt <= '0;
                case (state)
                    periph_pkg::START: begin
                        state   <= periph_pkg::DATA;
                        bit_cnt <= '0;
                    end
                    periph_pkg::DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= periph_pkg::STOP;
                        end
                    end
                    default: state <= periph_pkg::IDLE;
                endcase
            end
        end
    end

    // Shift register for the data bits
    always_ff @(posedge clk_i) begin
        if (load) begin
            shift <= wdata_i[7:0];
        end else if ((state == periph_pkg::DATA) && bit_done) begin
            shift <= shift >> 1;
        end
    end

    // Line idles high
    always_comb begin
        case (state)
            periph_pkg::START: tx_o = 1'b0;
            periph_pkg::DATA:  tx_o = shift[0];
            default:           tx_o = 1'b1;
        endcase
    end

    always_comb begin
        case (offset_i)
            periph_pkg::UART_STATUS: rdata_o = periph_pkg::data_t'(state != periph_pkg::IDLE);
            periph_pkg::UART_DIV:    rdata_o = div;
            periph_pkg::UART_CTRL:   rdata_o = periph_pkg::data_t'(irq_en);
            default:                 rdata_o = '0;
        endcase
    end

endmodule

/* source/soc_peripherals.sv */
/*
 * Peripheral subsystem top
 * One register bus feeding the decoder, compare timers, UART transmitter
 * and the interrupt controller for two targets
 */
`timescale 1ns/1ns

module soc_peripherals (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              req_i,
    input  logic              we_i,
    input  periph_pkg::addr_t addr_i,
    input  periph_pkg::data_t wdata_i,
    output logic              rsp_valid_o,
    output periph_pkg::data_t rdata_o,
    output logic              err_o,
    output logic [1:0]        irq_o,
    output logic              tx_o
);

    logic                               plic_sel;
    logic                               uart_sel;
    logic                               timer_sel;
    logic                               we;
    periph_pkg::offset_t                offset;
    periph_pkg::data_t                  wdata;
    periph_pkg::data_t                  plic_rdata;
    periph_pkg::data_t                  uart_rdata;
    periph_pkg::data_t                  timer_rdata;
    logic [periph_pkg::NUM_TIMERS-1:0]  timer_irq;
    logic                               uart_irq;
    logic [periph_pkg::NUM_SOURCES-1:0] irq_sources;

    // Source 1 and 2 are the timers, source 3 the UART
    assign irq_sources = {uart_irq, timer_irq};

    periph_reg_decode i_decode (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_i         (req_i),
        .we_i          (we_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .plic_sel_o    (plic_sel),
        .uart_sel_o    (uart_sel),
        .timer_sel_o   (timer_sel),
        .we_o          (we),
        .offset_o      (offset),
        .wdata_o       (wdata),
        .plic_rdata_i  (plic_rdata),
        .uart_rdata_i  (uart_rdata),
        .timer_rdata_i (timer_rdata),
        .rsp_valid_o   (rsp_valid_o),
        .rdata_o       (rdata_o),
        .err_o         (err_o)
    );

    periph_timer i_timer (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .sel_i    (timer_sel),
        .we_i     (we),
        .offset_i (offset),
        .wdata_i  (wdata),
        .rdata_o  (timer_rdata),
        .irq_o    (timer_irq)
    );

    periph_uart_tx i_uart (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .sel_i    (uart_sel),
        .we_i     (we),
        .offset_i (offset),
        .wdata_i  (wdata),
        .rdata_o  (uart_rdata),
        .irq_o    (uart_irq),
        .tx_o     (tx_o)
    );

    periph_plic i_plic (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .sel_i    (plic_sel),
        .we_i     (we),
        .offset_i (offset),
        .wdata_i  (wdata),
        .rdata_o  (plic_rdata),
        .src_i    (irq_sources),
        .irq_o    (irq_o)
    );

endmodule

/* verification/soc_peripherals_testdata.txt */
// Columns: command, address, write data, expected value (all hex)
// 0 end, 1 test start (data = test id), 2 write, 3 read, 4 read error, 5 write error, 6 wait irq_o, 7 UART frame
1 000 00000000 00000000
3 108 00000000 00000004
2 208 00001234 00000000
3 208 00000000 00001234
2 108 00000006 00000000
3 108 00000000 00000006
2 004 00000002 00000000
3 004 00000000 00000002
1 000 00000001 00000000
4 500 00000000 DEADBEEF
5 508 FFFFFFFF 00000000
3 208 00000000 00001234
3 108 00000000 00000006
3 008 00000000 00000000
1 000 00000002 00000000
2 040 00000002 00000000
2 208 00000010 00000000
2 200 00000001 00000000
6 000 00000000 00000001
3 080 00000000 00000001
6 000 00000000 00000000
2 200 00000000 00000000
2 20C 00000001 00000000
2 080 00000001 00000000
3 020 00000000 00000000
1 000 00000003 00000000
2 004 00000003 00000000
2 008 00000005 00000000
2 040 00000006 00000000
2 218 00000000 00000000
2 208 00000000 00000000
2 204 00000000 00000000
2 210 00000001 00000000
2 200 00000001 00000000
6 000 00000000 00000001
3 080 00000000 00000002
2 060 00000005 00000000
3 020 00000000 00000002
6 000 00000000 00000000
3 080 00000000 00000000
1 000 00000004 00000000
2 108 00000006 00000000
2 100 000000A5 00000000
3 104 00000000 00000001
2 10C 00000001 00000000
2 00C 00000004 00000000
2 044 00000008 00000000
7 000 00000000 000000A5
6 000 00000000 00000002
3 084 00000000 00000003
3 104 00000000 00000000
0 000 00000000 00000000

/* verification/tb_soc_peripherals.sv */
/*
 * Testbench for the peripheral subsystem
 * Replays register commands from a data file and checks bus responses,
 * interrupt lines and UART frames
 */
`timescale 1ns/1ns

module tb_soc_peripherals;

    localparam int MEM_WORDS     = 512;
    localparam int RSP_TIMEOUT   = 10;
    localparam int IRQ_TIMEOUT   = 200;
    localparam int FRAME_TIMEOUT = 150;
    // Clocks per bit that the data file programs before the frame test
    localparam int BIT_CYCLES    = 6;

    // Command codes of the data file
    localparam logic [31:0] CMD_END       = 32'h0;
    localparam logic [31:0] CMD_MARK      = 32'h1;
    localparam logic [31:0] CMD_WRITE     = 32'h2;
    localparam logic [31:0] CMD_READ      = 32'h3;
    localparam logic [31:0] CMD_READ_ERR  = 32'h4;
    localparam logic [31:0] CMD_WRITE_ERR = 32'h5;
    localparam logic [31:0] CMD_WAIT_IRQ  = 32'h6;
    localparam logic [31:0] CMD_FRAME     = 32'h7;

    logic              clk_i;
    logic              reset_i;
    logic              req_i;
    logic              we_i;
    periph_pkg::addr_t addr_i;
    periph_pkg::data_t wdata_i;
    logic              rsp_valid_o;
    periph_pkg::data_t rdata_o;
    logic              err_o;
    logic [1:0]        irq_o;
    logic              tx_o;

    logic [31:0] cmd_mem [MEM_WORDS];
    logic [9:0]  frame_q [$];
    logic        mon_active;
    int          mon_cnt;
    logic [9:0]  mon_bits;
    logic        req_seen;
    string       test_name;
    logic        test_open;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int          seed_dummy;

    soc_peripherals u_soc_peripherals (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rdata_o     (rdata_o),
        .err_o       (err_o),
        .irq_o       (irq_o),
        .tx_o        (tx_o)
    );

    always #2 clk_i = ~clk_i;

    // --------------------------------------------------
    // UART line monitor
    // --------------------------------------------------
    // Count starts when the start bit is seen and each bit is sampled in its middle
    always @(negedge clk_i) begin
        if (reset_i) begin
            mon_active = 1'b0;
            mon_cnt    = 0;
        end else if (!mon_active) begin
            if (tx_o == 1'b0) begin
                mon_active = 1'b1;
                mon_cnt    = 0;
            end
        end else begin
            mon_cnt++;
            if (mon_cnt % BIT_CYCLES == BIT_CYCLES / 2) begin
                mon_bits[mon_cnt / BIT_CYCLES] = tx_o;
                if (mon_cnt / BIT_CYCLES == 9) begin
                    frame_q.push_back(mon_bits);
                    mon_active = 1'b0;
                end
            end
        end
    end

    // --------------------------------------------------
    // Response strobe monitor
    // --------------------------------------------------
    // A response follows each request edge and no other
    always @(negedge clk_i) begin
        if (reset_i) begin
            req_seen = 1'b0;
        end else begin
            assert (rsp_valid_o === req_seen) else report_error($sformatf(
                "test %s: rsp_valid_o was %b one cycle after req_i was %b",
                test_name, rsp_valid_o, req_seen));
            req_seen = req_i;
        end
    end

    function automatic string name_of_test(input logic [31:0] idx);
        case (idx)
            32'd0:   return "readback";
            32'd1:   return "unmapped";
            32'd2:   return "timer_irq";
            32'd3:   return "prio_thresh";
            32'd4:   return "uart_frame";
            default: return "unnamed";
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        test_errors++;
        total_errors++;
    endtask

    task automatic close_test();
        if (test_open) begin
            tests_run++;
            if (test_errors > 0) begin
                tests_failed++;
            end
            $display("test %s done with %0d errors", test_name, test_errors);
        end
        test_open = 1'b0;
    endtask

    task automatic idle_gap();
        int n;
        n = $urandom % 4;
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // Drives one request strobe and waits for the registered response
    task automatic bus_access(input logic is_write, input logic [31:0] addr,
                              input logic [31:0] data, output periph_pkg::data_t rdata,
                              output logic err);
        int cycles;
        req_i   = 1'b1;
        we_i    = is_write;
        addr_i  = periph_pkg::addr_t'(addr);
        wdata_i = data;
        @(posedge clk_i);
        #1;
        req_i  = 1'b0;
        we_i   = 1'b0;
        cycles = 1;
        while (!rsp_valid_o && cycles < RSP_TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        rdata = rdata_o;
        err   = err_o;
        assert (rsp_valid_o) else report_error($sformatf(
            "test %s: no response within %0d cycles for address %h",
            test_name, RSP_TIMEOUT, addr[11:0]));
        assert (!rsp_valid_o || cycles == 1) else report_error($sformatf(
            "test %s: response came %0d cycles after the request", test_name, cycles));
    endtask

    task automatic wait_irq(input logic [31:0] expected);
        int cycles;
        cycles = 0;
        while (irq_o !== expected[1:0] && cycles < IRQ_TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        assert (irq_o === expected[1:0]) else report_error($sformatf(
            "test %s: irq_o did not reach %b within %0d cycles and stayed at %b",
            test_name, expected[1:0], IRQ_TIMEOUT, irq_o));
    endtask

    task automatic wait_frame(input logic [31:0] expected);
        int         cycles;
        logic [9:0] frame;
        cycles = 0;
        while (frame_q.size() == 0 && cycles < FRAME_TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cycles++;
        end
        assert (frame_q.size() > 0) else report_error($sformatf(
            "test %s: no UART frame within %0d cycles", test_name, FRAME_TIMEOUT));
        if (frame_q.size() > 0) begin
            frame = frame_q.pop_front();
            assert (frame[0] === 1'b0) else report_error($sformatf(
                "test %s: UART start bit was not low", test_name));
            assert (frame[9] === 1'b1) else report_error($sformatf(
                "test %s: UART stop bit was not high", test_name));
            assert (frame[8:1] === expected[7:0]) else report_error($sformatf(
                "[ERROR] test %s: UART byte expected %h actual %h",
                test_name, expected[7:0], frame[8:1]));
        end
    endtask

    // --------------------------------------------------
    // Command replay
    // --------------------------------------------------
    initial begin
        logic [31:0]       cmd;
        logic [31:0]       addr;
        logic [31:0]       data;
        logic [31:0]       expected;
        periph_pkg::data_t rdata;
        logic              err;
        int                pc;
        logic              done;

        clk_i        = 1'b0;
        reset_i      = 1'b1;
        req_i        = 1'b0;
        we_i         = 1'b0;
        addr_i       = '0;
        wdata_i      = '0;
        test_open    = 1'b0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "none";
        seed_dummy   = $urandom(57610);
        for (int i = 0; i < MEM_WORDS; i++) begin
            cmd_mem[i] = '0;
        end
        $readmemh("verification/soc_peripherals_testdata.txt", cmd_mem);

        repeat (4) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        pc   = 0;
        done = 1'b0;
        while (!done) begin
            cmd      = cmd_mem[pc];
            addr     = cmd_mem[pc + 1];
            data     = cmd_mem[pc + 2];
            expected = cmd_mem[pc + 3];
            pc       = pc + 4;
            if (cmd != CMD_MARK && cmd != CMD_END) begin
                idle_gap();
            end
            case (cmd)
                CMD_END: begin
                    done = 1'b1;
                end
                CMD_MARK: begin
                    close_test();
                    test_name   = name_of_test(data);
                    test_errors = 0;
                    test_open   = 1'b1;
                end
                CMD_WRITE: begin
                    bus_access(1'b1, addr, data, rdata, err);
                    assert (err === 1'b0) else report_error($sformatf(
                        "test %s: unexpected error response on write to %h",
                        test_name, addr[11:0]));
                end
                CMD_READ: begin
                    bus_access(1'b0, addr, '0, rdata, err);
                    assert (err === 1'b0) else report_error($sformatf(
                        "test %s: unexpected error response on read of %h",
                        test_name, addr[11:0]));
                    assert (rdata === expected) else report_error($sformatf(
                        "[ERROR] test %s: read %h expected %h actual %h",
                        test_name, addr[11:0], expected, rdata));
                end
                CMD_READ_ERR: begin
                    bus_access(1'b0, addr, '0, rdata, err);
                    assert (err === 1'b1) else report_error($sformatf(
                        "test %s: no error response on read of %h", test_name, addr[11:0]));
                    assert (rdata === expected) else report_error($sformatf(
                        "[ERROR] test %s: read %h expected %h actual %h",
                        test_name, addr[11:0], expected, rdata));
                end
                CMD_WRITE_ERR: begin
                    bus_access(1'b1, addr, data, rdata, err);
                    assert (err === 1'b1) else report_error($sformatf(
                        "test %s: no error response on write to %h", test_name, addr[11:0]));
                end
                CMD_WAIT_IRQ: begin
                    wait_irq(expected);
                end
                CMD_FRAME: begin
                    wait_frame(expected);
                end
                default: begin
                    report_error($sformatf("unknown command %h in the data file", cmd));
                    done = 1'b1;
                end
            endcase
            if (pc + 4 > MEM_WORDS) begin
                done = 1'b1;
            end
        end

        close_test();
        assert (tests_run > 0) else report_error("no tests were found in the data file");
        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
